// File: hdl/chip_pkg.sv
// Chip-level constants
// Pad counts, JTAG lane map, tie-offs and TAP instruction codes
`default_nettype none

package chip_pkg;

  ////////////////////////////////////////
  // Pad counts
  ////////////////////////////////////////

  localparam int NumMioPads = 8;
  localparam int NumDioPads = 4;
  localparam int NumIos     = NumMioPads + NumDioPads;  // MIO lanes first, then DIO

  ////////////////////////////////////////
  // JTAG lane indices
  ////////////////////////////////////////

  localparam int JtagEnIdx = 6;               // Strap, JTAG active while high
  localparam int TrstIdx   = 7;
  localparam int TckIdx    = NumMioPads + 0;
  localparam int TmsIdx    = NumMioPads + 1;
  localparam int TdiIdx    = NumMioPads + 2;
  localparam int TdoIdx    = NumMioPads + 3;

  // Lanes taken over while JTAG is active
  localparam logic [NumIos-1:0] JtagLaneMask = (NumIos'(1) << JtagEnIdx) |
                                               (NumIos'(1) << TrstIdx)   |
                                               (NumIos'(1) << TckIdx)    |
                                               (NumIos'(1) << TmsIdx)    |
                                               (NumIos'(1) << TdiIdx)    |
                                               (NumIos'(1) << TdoIdx);

  // Core sees idle-high TMS and TRST_N on taken lanes
  localparam logic [NumIos-1:0] TieOffValues = (NumIos'(1) << TmsIdx) |
                                               (NumIos'(1) << TrstIdx);

  ////////////////////////////////////////
  // TAP
  ////////////////////////////////////////

  localparam int          IrWidth = 4;
  localparam logic [31:0] IdCode  = 32'h1b07_3a5d;

  localparam logic [IrWidth-1:0] InstrIdcode   = 4'd1;
  localparam logic [IrWidth-1:0] InstrGpioOut  = 4'd2;
  localparam logic [IrWidth-1:0] InstrGpioOe   = 4'd3;
  localparam logic [IrWidth-1:0] InstrGpioAttr = 4'd4;
  localparam logic [IrWidth-1:0] InstrGpioIn   = 4'd5;
  localparam logic [IrWidth-1:0] InstrBypass   = 4'd15;

  // Register selector for TAP updates into the GPIO block
  typedef enum logic [1:0] {
    GpioSelOut  = 2'd0,
    GpioSelOe   = 2'd1,
    GpioSelAttr = 2'd2
  } gpio_sel_e;

endpackage : chip_pkg

`default_nettype wire

// File: hdl/padring.sv
// Padring
// Tristate pad drivers and synchronized pad inputs with per-pad invert
`timescale 1ns/1ps
`default_nettype none

module padring (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  // Pads
  inout  wire  [chip_pkg::NumMioPads-1:0] mio_pad_io,
  inout  wire  [chip_pkg::NumDioPads-1:0] dio_pad_io,
  // Core-side lanes, MIO in the low bits
  input  logic [chip_pkg::NumIos-1:0]  pad_out_i,
  input  logic [chip_pkg::NumIos-1:0]  pad_oe_i,
  input  logic [chip_pkg::NumIos-1:0]  attr_i,
  output logic [chip_pkg::NumIos-1:0]  pad_in_o
);

  logic [chip_pkg::NumIos-1:0] pad_drive;
  logic [chip_pkg::NumIos-1:0] pad_raw;
  logic [chip_pkg::NumIos-1:0] sync_q1, sync_q2;

  ////////////////////////////////////////
  // Output drivers
  ////////////////////////////////////////

  assign pad_drive = pad_out_i ^ attr_i;  // Invert attribute on the way out

  for (genvar i = 0; i < chip_pkg::NumMioPads; i++) begin : g_mio_drv
    assign mio_pad_io[i] = pad_oe_i[i] ? pad_drive[i] : 1'bz;
  end

  for (genvar i = 0; i < chip_pkg::NumDioPads; i++) begin : g_dio_drv
    // DIO lanes sit above the MIO lanes
    assign dio_pad_io[i] = pad_oe_i[chip_pkg::NumMioPads + i] ?
                           pad_drive[chip_pkg::NumMioPads + i] : 1'bz;
  end

  ////////////////////////////////////////
  // Input capture
  ////////////////////////////////////////

  assign pad_raw = {dio_pad_io, mio_pad_io} ^ attr_i;  // Same invert on the way in

  // Two-flop synchronizer on every lane
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      sync_q1 <= '0;
      sync_q2 <= '0;
    end else begin
      sync_q1 <= pad_raw;
      sync_q2 <= sync_q1;
    end
  end

  assign pad_in_o = sync_q2;

endmodule : padring

`default_nettype wire

// File: hdl/jtag_overlay_mux.sv
// JTAG overlay mux
// Strap pad hands five pads plus the strap to the TAP, core gets tie-offs
`timescale 1ns/1ps
`default_nettype none

module jtag_overlay_mux (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  // Padring side
  input  logic [chip_pkg::NumIos-1:0] pad_in_i,
  output logic [chip_pkg::NumIos-1:0] pad_out_o,
  output logic [chip_pkg::NumIos-1:0] pad_oe_o,
  // Core side
  input  logic [chip_pkg::NumIos-1:0] core_out_i,
  input  logic [chip_pkg::NumIos-1:0] core_oe_i,
  output logic [chip_pkg::NumIos-1:0] core_in_o,
  // TAP side
  output logic                        jtag_tck_o,
  output logic                        jtag_tms_o,
  output logic                        jtag_tdi_o,
  output logic                        jtag_trst_n_o,
  input  logic                        jtag_tdo_i,
  input  logic                        jtag_tdo_oe_i
);

  localparam logic [chip_pkg::NumIos-1:0] TdoMask = chip_pkg::NumIos'(1) << chip_pkg::TdoIdx;
  localparam logic [chip_pkg::NumIos-1:0] Mask    = chip_pkg::JtagLaneMask;

  logic jtag_en_q;

  // Registered strap select
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      jtag_en_q <= 1'b0;
    end else begin
      jtag_en_q <= pad_in_i[chip_pkg::JtagEnIdx];
    end
  end

  ////////////////////////////////////////
  // Lane steering
  ////////////////////////////////////////

  // Taken lanes go quiet except TDO, which the TAP owns
  assign pad_out_o = jtag_en_q ? ((core_out_i & ~Mask) | ({chip_pkg::NumIos{jtag_tdo_i}} & TdoMask))
                               : core_out_i;
  assign pad_oe_o  = jtag_en_q ? ((core_oe_i & ~Mask) | ({chip_pkg::NumIos{jtag_tdo_oe_i}} & TdoMask))
                               : core_oe_i;

  assign core_in_o = jtag_en_q ? ((pad_in_i & ~Mask) | (chip_pkg::TieOffValues & Mask))
                               : pad_in_i;

  // Idle values and TAP held in reset while the strap is low
  assign jtag_tck_o    = jtag_en_q ? pad_in_i[chip_pkg::TckIdx]  : 1'b0;
  assign jtag_tms_o    = jtag_en_q ? pad_in_i[chip_pkg::TmsIdx]  : 1'b1;
  assign jtag_tdi_o    = jtag_en_q ? pad_in_i[chip_pkg::TdiIdx]  : 1'b0;
  assign jtag_trst_n_o = jtag_en_q ? pad_in_i[chip_pkg::TrstIdx] : 1'b0;

endmodule : jtag_overlay_mux

`default_nettype wire

// File: hdl/jtag_tap.sv
// JTAG TAP controller running on the system clock
// TCK is oversampled, DRs are IDCODE, BYPASS and the GPIO registers
`timescale 1ns/1ps
`default_nettype none

module jtag_tap (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  // JTAG lanes, already synchronized
  input  logic                        jtag_tck_i,
  input  logic                        jtag_tms_i,
  input  logic                        jtag_tdi_i,
  input  logic                        jtag_trst_n_i,
  output logic                        jtag_tdo_o,
  output logic                        jtag_tdo_oe_o,
  // GPIO read-back
  input  logic [chip_pkg::NumIos-1:0] gpio_out_i,
  input  logic [chip_pkg::NumIos-1:0] gpio_oe_i,
  input  logic [chip_pkg::NumIos-1:0] gpio_attr_i,
  input  logic [chip_pkg::NumIos-1:0] gpio_in_i,
  // GPIO update
  output logic                        upd_valid_o,
  output chip_pkg::gpio_sel_e         upd_sel_o,
  output logic [chip_pkg::NumIos-1:0] upd_data_o
);

  typedef enum logic [3:0] {
    TestLogicReset, RunTestIdle, SelectDrScan, CaptureDr, ShiftDr, Exit1Dr, PauseDr,
    Exit2Dr, UpdateDr, SelectIrScan, CaptureIr, ShiftIr, Exit1Ir, PauseIr, Exit2Ir, UpdateIr
  } tap_state_e;

  tap_state_e                   state_q, state_d;
  logic [chip_pkg::IrWidth-1:0] ir_q, ir_shift_q;
  logic [31:0]                  dr_q, dr_capture, dr_shifted;
  logic                         tck_q, tdo_q, upd_en;
  logic                         tap_rst, tck_rise, tck_fall;

  assign tap_rst  = !rst_n_i || !jtag_trst_n_i;
  assign tck_rise =  jtag_tck_i & ~tck_q;  // One-flop edge detect
  assign tck_fall = ~jtag_tck_i &  tck_q;

  always_comb begin
    case (state_q)
      TestLogicReset: state_d = jtag_tms_i ? TestLogicReset : RunTestIdle;
      RunTestIdle:    state_d = jtag_tms_i ? SelectDrScan   : RunTestIdle;
      SelectDrScan:   state_d = jtag_tms_i ? SelectIrScan   : CaptureDr;
      CaptureDr:      state_d = jtag_tms_i ? Exit1Dr        : ShiftDr;
      ShiftDr:        state_d = jtag_tms_i ? Exit1Dr        : ShiftDr;
      Exit1Dr:        state_d = jtag_tms_i ? UpdateDr       : PauseDr;
      PauseDr:        state_d = jtag_tms_i ? Exit2Dr        : PauseDr;
      Exit2Dr:        state_d = jtag_tms_i ? UpdateDr       : ShiftDr;
      UpdateDr:       state_d = jtag_tms_i ? SelectDrScan   : RunTestIdle;
      SelectIrScan:   state_d = jtag_tms_i ? TestLogicReset : CaptureIr;
      CaptureIr:      state_d = jtag_tms_i ? Exit1Ir        : ShiftIr;
      ShiftIr:        state_d = jtag_tms_i ? Exit1Ir        : ShiftIr;
      Exit1Ir:        state_d = jtag_tms_i ? UpdateIr       : PauseIr;
      PauseIr:        state_d = jtag_tms_i ? Exit2Ir        : PauseIr;
      Exit2Ir:        state_d = jtag_tms_i ? UpdateIr       : ShiftIr;
      default:        state_d = jtag_tms_i ? SelectDrScan   : RunTestIdle;  // UpdateIr
    endcase
  end

  ////////////////////////////////////////
  // Instruction decode
  ////////////////////////////////////////

  always_comb begin
    dr_shifted = {1'b0, dr_q[31:1]};
    dr_capture = '0;
    upd_en     = 1'b0;
    upd_sel_o  = chip_pkg::GpioSelOut;
    case (ir_q)
      chip_pkg::InstrIdcode: begin
        dr_capture     = chip_pkg::IdCode;
        dr_shifted[31] = jtag_tdi_i;
      end
      chip_pkg::InstrGpioOut: begin
        dr_capture[chip_pkg::NumIos-1:0] = gpio_out_i;
        dr_shifted[chip_pkg::NumIos-1]   = jtag_tdi_i;
        upd_en = 1'b1;
      end
      chip_pkg::InstrGpioOe: begin
        dr_capture[chip_pkg::NumIos-1:0] = gpio_oe_i;
        dr_shifted[chip_pkg::NumIos-1]   = jtag_tdi_i;
        upd_en    = 1'b1;
        upd_sel_o = chip_pkg::GpioSelOe;
      end
      chip_pkg::InstrGpioAttr: begin
        dr_capture[chip_pkg::NumIos-1:0] = gpio_attr_i;
        dr_shifted[chip_pkg::NumIos-1]   = jtag_tdi_i;
        upd_en    = 1'b1;
        upd_sel_o = chip_pkg::GpioSelAttr;
      end
      chip_pkg::InstrGpioIn: begin  // Read-only
        dr_capture[chip_pkg::NumIos-1:0] = gpio_in_i;
        dr_shifted[chip_pkg::NumIos-1]   = jtag_tdi_i;
      end
      default: dr_shifted[0] = jtag_tdi_i;  // BYPASS and unknown codes
    endcase
  end

  ////////////////////////////////////////
  // Sequential
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (tap_rst) begin
      state_q <= TestLogicReset;
      ir_q    <= chip_pkg::InstrIdcode;
      tck_q   <= 1'b0;
      tdo_q   <= 1'b0;
    end else begin
      tck_q <= jtag_tck_i;
      if (tck_rise) begin
        state_q <= state_d;
        if (state_q == TestLogicReset) ir_q <= chip_pkg::InstrIdcode;
        if (state_d == UpdateIr)       ir_q <= ir_shift_q;
      end
      if (tck_fall) begin
        tdo_q <= (state_q == ShiftIr) ? ir_shift_q[0] : dr_q[0];
      end
    end
  end

  // Shift paths
  always_ff @(posedge clk_i) begin
    if (tck_rise) begin
      case (state_q)
        CaptureIr: ir_shift_q <= chip_pkg::IrWidth'(1);
        ShiftIr:   ir_shift_q <= {jtag_tdi_i, ir_shift_q[chip_pkg::IrWidth-1:1]};
        CaptureDr: dr_q       <= dr_capture;
        ShiftDr:   dr_q       <= dr_shifted;
        default: ;
      endcase
    end
  end

  assign jtag_tdo_o    = tdo_q;
  assign jtag_tdo_oe_o = (state_q == ShiftDr) || (state_q == ShiftIr);

  // Pulse on the edge that enters Update-DR
  assign upd_valid_o = tck_rise && upd_en && (state_d == UpdateDr);
  assign upd_data_o  = dr_q[chip_pkg::NumIos-1:0];

endmodule : jtag_tap

`default_nettype wire

// File: hdl/gpio_ctrl.sv
// GPIO controller
// Output, output-enable and invert registers loaded by TAP updates
`timescale 1ns/1ps
`default_nettype none

module gpio_ctrl (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  // Update from the TAP
  input  logic                        upd_valid_i,
  input  chip_pkg::gpio_sel_e         upd_sel_i,
  input  logic [chip_pkg::NumIos-1:0] upd_data_i,
  // To the lanes
  output logic [chip_pkg::NumIos-1:0] core_out_o,
  output logic [chip_pkg::NumIos-1:0] core_oe_o,
  output logic [chip_pkg::NumIos-1:0] attr_o,
  // Read-back to the TAP
  output logic [chip_pkg::NumIos-1:0] gpio_out_o,
  output logic [chip_pkg::NumIos-1:0] gpio_oe_o,
  output logic [chip_pkg::NumIos-1:0] gpio_attr_o
);

  logic [chip_pkg::NumIos-1:0] out_q, oe_q, attr_q;

  // Always accepts, one register per pulse
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      out_q  <= '0;
      oe_q   <= '0;  // All pads released
      attr_q <= '0;
    end else if (upd_valid_i) begin
      case (upd_sel_i)
        chip_pkg::GpioSelOut:  out_q  <= upd_data_i;
        chip_pkg::GpioSelOe:   oe_q   <= upd_data_i;
        chip_pkg::GpioSelAttr: attr_q <= upd_data_i;
        default: ;
      endcase
    end
  end

  assign core_out_o = out_q;
  assign core_oe_o  = oe_q;
  assign attr_o     = attr_q;

  assign gpio_out_o  = out_q;
  assign gpio_oe_o   = oe_q;
  assign gpio_attr_o = attr_q;

endmodule : gpio_ctrl

`default_nettype wire

// File: hdl/chip_top.sv
// Chip top
// Padring, JTAG overlay, TAP and GPIO controller
`timescale 1ns/1ps
`default_nettype none

module chip_top (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  inout  wire  [chip_pkg::NumMioPads-1:0] mio_pad_io,
  inout  wire  [chip_pkg::NumDioPads-1:0] dio_pad_io
);

  logic [chip_pkg::NumIos-1:0] pad_in, pad_out, pad_oe;
  logic [chip_pkg::NumIos-1:0] core_in, core_out, core_oe, attr;
  logic [chip_pkg::NumIos-1:0] gpio_out, gpio_oe, gpio_attr, upd_data;
  logic                        jtag_tck, jtag_tms, jtag_tdi, jtag_trst_n;
  logic                        jtag_tdo, jtag_tdo_oe, upd_valid;
  chip_pkg::gpio_sel_e         upd_sel;

  ////////////////////////////////////////
  // Pads
  ////////////////////////////////////////

  padring padring (
    .clk_i      ( clk_i      ),
    .rst_n_i    ( rst_n_i    ),
    .mio_pad_io ( mio_pad_io ),
    .dio_pad_io ( dio_pad_io ),
    .pad_out_i  ( pad_out    ),
    .pad_oe_i   ( pad_oe     ),
    .attr_i     ( attr       ),
    .pad_in_o   ( pad_in     )
  );

  jtag_overlay_mux jtag_overlay_mux (
    .clk_i         ( clk_i       ),
    .rst_n_i       ( rst_n_i     ),
    .pad_in_i      ( pad_in      ),
    .pad_out_o     ( pad_out     ),
    .pad_oe_o      ( pad_oe      ),
    .core_out_i    ( core_out    ),
    .core_oe_i     ( core_oe     ),
    .core_in_o     ( core_in     ),
    .jtag_tck_o    ( jtag_tck    ),
    .jtag_tms_o    ( jtag_tms    ),
    .jtag_tdi_o    ( jtag_tdi    ),
    .jtag_trst_n_o ( jtag_trst_n ),
    .jtag_tdo_i    ( jtag_tdo    ),
    .jtag_tdo_oe_i ( jtag_tdo_oe )
  );

  ////////////////////////////////////////
  // Core
  ////////////////////////////////////////

  jtag_tap jtag_tap (
    .clk_i         ( clk_i       ),
    .rst_n_i       ( rst_n_i     ),
    .jtag_tck_i    ( jtag_tck    ),
    .jtag_tms_i    ( jtag_tms    ),
    .jtag_tdi_i    ( jtag_tdi    ),
    .jtag_trst_n_i ( jtag_trst_n ),
    .jtag_tdo_o    ( jtag_tdo    ),
    .jtag_tdo_oe_o ( jtag_tdo_oe ),
    .gpio_out_i    ( gpio_out    ),
    .gpio_oe_i     ( gpio_oe     ),
    .gpio_attr_i   ( gpio_attr   ),
    .gpio_in_i     ( core_in     ),  // GPIO_IN reads the core-side lanes
    .upd_valid_o   ( upd_valid   ),
    .upd_sel_o     ( upd_sel     ),
    .upd_data_o    ( upd_data    )
  );

  gpio_ctrl gpio_ctrl (
    .clk_i       ( clk_i     ),
    .rst_n_i     ( rst_n_i   ),
    .upd_valid_i ( upd_valid ),
    .upd_sel_i   ( upd_sel   ),
    .upd_data_i  ( upd_data  ),
    .core_out_o  ( core_out  ),
    .core_oe_o   ( core_oe   ),
    .attr_o      ( attr      ),
    .gpio_out_o  ( gpio_out  ),
    .gpio_oe_o   ( gpio_oe   ),
    .gpio_attr_o ( gpio_attr )
  );

endmodule : chip_top

`default_nettype wire

// File: dv/chip_assertions.sv
// Overlay and TAP checks
// Bound into the chip top, reaches the mux and TAP instances
`timescale 1ns/1ps
`default_nettype none

module chip_assertions (
  input logic                        clk_i,
  input logic                        rst_n_i,
  input logic                        jtag_en_i,
  input logic [chip_pkg::NumIos-1:0] pad_oe_i,
  input logic [3:0]                  tap_state_i,
  input logic                        upd_valid_i
);

  localparam logic [3:0] ShiftDrState = 4'd4;   // TAP state encodings
  localparam logic [3:0] ShiftIrState = 4'd11;

  // Lanes the TAP listens on
  localparam logic [chip_pkg::NumIos-1:0] JtagInMask = (chip_pkg::NumIos'(1) << chip_pkg::TckIdx) |
                                                       (chip_pkg::NumIos'(1) << chip_pkg::TmsIdx) |
                                                       (chip_pkg::NumIos'(1) << chip_pkg::TdiIdx) |
                                                       (chip_pkg::NumIos'(1) << chip_pkg::TrstIdx);

  // TDO pad enable as seen after the overlay steering
  tdo_oe_in_shift: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (jtag_en_i && pad_oe_i[chip_pkg::TdoIdx]) |->
      (tap_state_i == ShiftDrState || tap_state_i == ShiftIrState))
    else $error("TDO pad enabled outside Shift-DR and Shift-IR");

  jtag_inputs_released: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    jtag_en_i |-> ((pad_oe_i & JtagInMask) == '0))
    else $error("JTAG input lane driven while JTAG is active");

  upd_single_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    upd_valid_i |=> !upd_valid_i)
    else $error("Update pulse longer than one cycle");

endmodule : chip_assertions

bind chip_top chip_assertions checks (
  .clk_i       ( clk_i                      ),
  .rst_n_i     ( rst_n_i                    ),
  .jtag_en_i   ( jtag_overlay_mux.jtag_en_q ),
  .pad_oe_i    ( pad_oe                     ),
  .tap_state_i ( jtag_tap.state_q           ),
  .upd_valid_i ( upd_valid                  )
);

`default_nettype wire

// File: dv/chip_tb.sv
// Chip testbench
// Runs JTAG on the pads and checks GPIO drive, capture and invert
`timescale 1ns/1ps
`default_nettype none

module chip_tb;

  localparam int CycleLimit = 12000;  // Six tests of up to 150 TCK periods, 8 clk each, plus margin
  localparam logic [chip_pkg::NumIos-1:0] TieOff = (chip_pkg::NumIos'(1) << chip_pkg::TmsIdx) |
                                                   (chip_pkg::NumIos'(1) << chip_pkg::TrstIdx);

  logic                        clk, rst_n;
  logic [chip_pkg::NumIos-1:0] drv_val, drv_en;  // Testbench side of each pad
  wire  [chip_pkg::NumMioPads-1:0] mio_pad;
  wire  [chip_pkg::NumDioPads-1:0] dio_pad;
  wire  [chip_pkg::NumIos-1:0]     pad_lanes;
  integer                      seed;
  int                          error_count, check_count;
  int unsigned                 cycle_count;
  logic [11:0]                 out_val, oe_val;

  for (genvar i = 0; i < chip_pkg::NumMioPads; i++) begin : g_mio_drv
    assign mio_pad[i] = drv_en[i] ? drv_val[i] : 1'bz;
  end
  for (genvar i = 0; i < chip_pkg::NumDioPads; i++) begin : g_dio_drv
    assign dio_pad[i] = drv_en[chip_pkg::NumMioPads + i] ?
                        drv_val[chip_pkg::NumMioPads + i] : 1'bz;
  end
  assign pad_lanes = {dio_pad, mio_pad};

  chip_top dut_i (
    .clk_i      ( clk     ),
    .rst_n_i    ( rst_n   ),
    .mio_pad_io ( mio_pad ),
    .dio_pad_io ( dio_pad )
  );

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= CycleLimit) begin
      $display("Timeout: no result after %0d clock cycles", CycleLimit);
      $display("Checks: %0d, errors: %0d", check_count, error_count);
      $display("tests failed");
      $finish;
    end
  end

  ////////////////////////////////////////
  // JTAG and check helpers
  ////////////////////////////////////////

  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  // One TCK period, TDO sampled at the end of the low phase
  task automatic jtag_bit(input logic tms, input logic tdi, output logic tdo);
    drv_val[chip_pkg::TckIdx] = 1'b0;
    drv_val[chip_pkg::TmsIdx] = tms;
    drv_val[chip_pkg::TdiIdx] = tdi;
    repeat (4) next_cycle();
    tdo = pad_lanes[chip_pkg::TdoIdx];
    drv_val[chip_pkg::TckIdx] = 1'b1;
    repeat (4) next_cycle();
  endtask

  // Run-Test-Idle to Run-Test-Idle, LSB first
  task automatic load_ir(input logic [chip_pkg::IrWidth-1:0] instr);
    logic tdo_bit;
    jtag_bit(1'b1, 1'b0, tdo_bit);
    jtag_bit(1'b1, 1'b0, tdo_bit);  // Select-IR
    jtag_bit(1'b0, 1'b0, tdo_bit);
    jtag_bit(1'b0, 1'b0, tdo_bit);  // Shift-IR
    for (int i = 0; i < chip_pkg::IrWidth; i++) begin
      jtag_bit(i == chip_pkg::IrWidth - 1, instr[i], tdo_bit);
    end
    jtag_bit(1'b1, 1'b0, tdo_bit);  // Update-IR
    jtag_bit(1'b0, 1'b0, tdo_bit);
  endtask

  task automatic scan_dr(input int len, input logic [31:0] din, output logic [31:0] dout);
    logic tdo_bit;
    dout = '0;
    jtag_bit(1'b1, 1'b0, tdo_bit);
    jtag_bit(1'b0, 1'b0, tdo_bit);  // Capture-DR
    jtag_bit(1'b0, 1'b0, tdo_bit);
    for (int i = 0; i < len; i++) begin
      jtag_bit(i == len - 1, din[i], tdo_bit);
      dout[i] = tdo_bit;
    end
    jtag_bit(1'b1, 1'b0, tdo_bit);  // Update-DR
    jtag_bit(1'b0, 1'b0, tdo_bit);
  endtask

  task automatic access_gpio(input logic [3:0] instr, input logic [11:0] din,
                             output logic [11:0] dout);
    logic [31:0] raw;
    load_ir(instr);
    scan_dr(12, {20'd0, din}, raw);
    dout = raw[11:0];
  endtask

  task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
    check_count++;
    assert (act === exp) else begin
      error_count++;
      $display("** Error: %s expected %h, actual %h", name, exp, act);
    end
  endtask

  // MIO 0..5 are the free GPIO pads
  function automatic logic [5:0] pad_levels(input logic [5:0] oe, input logic [5:0] val);
    logic [5:0] levels;
    for (int i = 0; i < 6; i++) begin
      levels[i] = oe[i] ? val[i] : 1'bz;
    end
    return levels;
  endfunction

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////

  task automatic reset_and_idcode();
    logic        tdo_bit;
    logic [31:0] dout;
    check_eq("reset_idcode", {26'd0, 6'bzzzzzz}, {26'd0, pad_lanes[5:0]});
    check_eq("reset_idcode", {31'd0, 1'bz}, {31'd0, pad_lanes[chip_pkg::TdoIdx]});
    repeat (5) jtag_bit(1'b1, 1'b0, tdo_bit);  // Test-Logic-Reset
    jtag_bit(1'b0, 1'b0, tdo_bit);
    scan_dr(32, 32'd0, dout);
    check_eq("reset_idcode", chip_pkg::IdCode, dout);
  endtask

  task automatic bypass_delay();
    logic [31:0] din, dout;
    din = {16'd0, 16'($random(seed))};
    load_ir(chip_pkg::InstrBypass);
    scan_dr(16, din, dout);
    check_eq("bypass", {16'd0, din[14:0], 1'b0}, dout);  // One-bit delay
  endtask

  task automatic output_drive();
    logic [11:0] rd;
    oe_val  = 12'($random(seed));  // JTAG lanes too, the overlay keeps them off the pads
    out_val = 12'($random(seed));
    access_gpio(chip_pkg::InstrGpioOe, oe_val, rd);
    access_gpio(chip_pkg::InstrGpioOut, out_val, rd);
    check_eq("outputs", {26'd0, pad_levels(oe_val[5:0], out_val[5:0])}, {26'd0, pad_lanes[5:0]});
    access_gpio(chip_pkg::InstrGpioOut, out_val, rd);
    check_eq("outputs", {20'd0, out_val}, {20'd0, rd});
    access_gpio(chip_pkg::InstrGpioOe, oe_val, rd);
    check_eq("outputs", {20'd0, oe_val}, {20'd0, rd});
  endtask

  task automatic input_capture(input string name, input logic [5:0] invert);
    logic [11:0] rd;
    logic [5:0]  in_val;
    access_gpio(chip_pkg::InstrGpioOe, 12'd0, rd);
    in_val       = 6'($random(seed));
    drv_val[5:0] = in_val;
    drv_en[5:0]  = 6'h3f;
    access_gpio(chip_pkg::InstrGpioIn, 12'd0, rd);
    check_eq(name, {20'd0, TieOff | {6'd0, in_val ^ invert}}, {20'd0, rd});
    drv_en[5:0] = 6'h00;
  endtask

  task automatic invert_attr();
    logic [11:0] rd;
    access_gpio(chip_pkg::InstrGpioAttr, 12'h03f, rd);
    oe_val = 12'($random(seed)) & 12'h03f;
    access_gpio(chip_pkg::InstrGpioOe, oe_val, rd);
    check_eq("invert", {26'd0, pad_levels(oe_val[5:0], ~out_val[5:0])}, {26'd0, pad_lanes[5:0]});
    access_gpio(chip_pkg::InstrGpioAttr, 12'h03f, rd);
    check_eq("invert", 32'h03f, {20'd0, rd});
    input_capture("invert", 6'h3f);
  endtask

  task automatic overlay_release();
    logic        tdo_bit;
    logic [31:0] dout;
    drv_val[chip_pkg::JtagEnIdx] = 1'b0;
    repeat (4) next_cycle();  // Synchronizer plus strap register
    check_eq("overlay_release", {31'd0, 1'bz}, {31'd0, pad_lanes[chip_pkg::TdoIdx]});
    load_ir(chip_pkg::InstrGpioOut);  // TAP is held in reset, so this is lost
    drv_val[chip_pkg::TckIdx]    = 1'b0;
    drv_val[chip_pkg::JtagEnIdx] = 1'b1;
    repeat (4) next_cycle();
    jtag_bit(1'b0, 1'b0, tdo_bit);
    scan_dr(32, 32'd0, dout);
    check_eq("overlay_release", chip_pkg::IdCode, dout);
  endtask

  initial begin
    seed        = 32'ha10c_ffb0;
    error_count = 0;
    check_count = 0;
    cycle_count = 0;
    clk         = 1'b0;
    rst_n       = 1'b0;
    drv_val     = '0;
    drv_en      = '0;
    // Strap, TRST_N, TCK, TMS and TDI come from the testbench
    drv_en[chip_pkg::JtagEnIdx] = 1'b1;
    drv_en[chip_pkg::TrstIdx]   = 1'b1;
    drv_en[chip_pkg::TckIdx]    = 1'b1;
    drv_en[chip_pkg::TmsIdx]    = 1'b1;
    drv_en[chip_pkg::TdiIdx]    = 1'b1;
    drv_val[chip_pkg::JtagEnIdx] = 1'b1;
    drv_val[chip_pkg::TrstIdx]   = 1'b1;
    drv_val[chip_pkg::TmsIdx]    = 1'b1;
    repeat (5) @(posedge clk);
    #2;
    rst_n = 1'b1;
    repeat (4) next_cycle();

    reset_and_idcode();
    bypass_delay();
    output_drive();
    input_capture("inputs", 6'h00);
    invert_attr();
    overlay_release();

    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule : chip_tb

`default_nettype wire

// File: project.f
hdl/chip_pkg.sv
hdl/padring.sv
hdl/jtag_overlay_mux.sv
hdl/jtag_tap.sv
hdl/gpio_ctrl.sv
hdl/chip_top.sv
dv/chip_assertions.sv
dv/chip_tb.sv
